/* verilog/round_pkg.sv */
`default_nettype none

package round_pkg;

    //////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////

    typedef logic [7:0]   byte_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] block_t;

    // Rotated T-words of one state column, p0 in the top bits
    typedef struct packed {
        word_t p0;
        word_t p1;
        word_t p2;
        word_t p3;
    } column_words_t;

    //////////////////////////////////////////////////
    // Chain constants
    //////////////////////////////////////////////////

    localparam int NUM_ROUNDS       = 20;
    localparam int CYCLES_PER_ROUND = 2;
    localparam int CHAIN_LATENCY    = NUM_ROUNDS * CYCLES_PER_ROUND;

    // Whitening constant, also the state input of every round
    localparam block_t CHAIN_STATE     = 128'hc2f45dfa_8acd3f4d_a3dcfe8a_93cefa0a;
    localparam block_t DEFAULT_TRIGGER = 128'h6939b2e8_98f96935_09673257_82ecc94e;

    //////////////////////////////////////////////////
    // GF(2^8) arithmetic, polynomial x^8+x^4+x^3+x+1
    //////////////////////////////////////////////////

    function automatic byte_t xtime(input byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // Shift-and-add multiply
    function automatic byte_t gf_mul(input byte_t a, input byte_t b);
        byte_t acc;
        byte_t sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // Inverse as b^254, then the affine map; zero maps to 63
    function automatic byte_t sbox(input byte_t b);
        byte_t sq;
        byte_t inv;
        sq  = b;
        inv = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);
            inv = gf_mul(inv, sq);
        end
        return inv
            ^ {inv[6:0], inv[7]}
            ^ {inv[5:0], inv[7:6]}
            ^ {inv[4:0], inv[7:5]}
            ^ {inv[3:0], inv[7:4]}
            ^ 8'h63;
    endfunction

endpackage

`default_nettype wire

/* verilog/t_word_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

// One T-table entry: {S, S, 3*S, 2*S} for a single input byte
module t_word_lookup (
    input  logic            clk,
    input  round_pkg::byte_t in_byte,
    output round_pkg::word_t t_word
);

    import round_pkg::*;

    byte_t s_next;
    byte_t xs_next;
    byte_t s_q;
    byte_t xs_q;

    // Substitution and its doubling, both combinational
    assign s_next  = sbox(in_byte);
    assign xs_next = xtime(s_next);

    //////////////////////////////////////////////////
    // Lookup register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        s_q  <= s_next;
        xs_q <= xs_next;
    end

    // Third byte is S*(x+1)
    assign t_word = {s_q, s_q, s_q ^ xs_q, xs_q};

endmodule

`default_nettype wire

/* verilog/round_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

// T-table lookup of one 32-bit column
module round_lookup (
    input  logic                    clk,
    input  round_pkg::word_t         column,
    output round_pkg::column_words_t words
);

    import round_pkg::*;

    word_t t_words [4];

    //////////////////////////////////////////////////
    // Per-byte lookups, byte 0 is the top byte
    //////////////////////////////////////////////////

    for (genvar i = 0; i < 4; i++) begin : g_byte
        t_word_lookup u_t_word_lookup (
            .clk     (clk),
            .in_byte (column[31 - 8*i -: 8]),
            .t_word  (t_words[i])
        );
    end

    //////////////////////////////////////////////////
    // Row rotations
    //////////////////////////////////////////////////

    // Right rotation by 8, 16 and 24 bits
    assign words.p0 = {t_words[0][7:0],  t_words[0][31:8]};
    assign words.p1 = {t_words[1][15:0], t_words[1][31:16]};
    assign words.p2 = {t_words[2][23:0], t_words[2][31:24]};

    // Last byte needs no rotation
    assign words.p3 = t_words[3];

endmodule

`default_nettype wire

/* verilog/cipher_round.sv */
`timescale 1ns/1ps
`default_nettype none

// One T-table AES round, two cycles from state and key to result
module cipher_round (
    input  logic             clk,
    input  round_pkg::block_t state,
    input  round_pkg::block_t round_key,
    output round_pkg::block_t result
);

    import round_pkg::*;

    column_words_t cols [4];
    block_t        key_q;
    word_t         z [4];

    for (genvar c = 0; c < 4; c++) begin : g_col
        round_lookup u_round_lookup (
            .clk    (clk),
            .column (state[127 - 32*c -: 32]),
            .words  (cols[c])
        );
    end

    // Key waits one cycle for the lookup register
    always_ff @(posedge clk) begin
        key_q <= round_key;
    end

    //////////////////////////////////////////////////
    // ShiftRows and MixColumns as T-word XOR
    //////////////////////////////////////////////////

    assign z[0] = cols[0].p0 ^ cols[1].p1 ^ cols[2].p2 ^ cols[3].p3 ^ key_q[127:96];
    assign z[1] = cols[0].p3 ^ cols[1].p0 ^ cols[2].p1 ^ cols[3].p2 ^ key_q[95:64];
    assign z[2] = cols[0].p2 ^ cols[1].p3 ^ cols[2].p0 ^ cols[3].p1 ^ key_q[63:32];
    assign z[3] = cols[0].p1 ^ cols[1].p2 ^ cols[2].p3 ^ cols[3].p0 ^ key_q[31:0];

    // Output register
    always_ff @(posedge clk) begin
        result <= {z[0], z[1], z[2], z[3]};
    end

endmodule

`default_nettype wire

/* verilog/round_chain.sv */
`timescale 1ns/1ps
`default_nettype none

// Whitened key through NUM_ROUNDS chained rounds
module round_chain (
    input  logic             clk,
    input  round_pkg::block_t key,
    output round_pkg::block_t chain_out
);

    import round_pkg::*;

    // Link r feeds round r as its key
    block_t links [NUM_ROUNDS + 1];

    //////////////////////////////////////////////////
    // Key whitening
    //////////////////////////////////////////////////

    assign links[0] = key ^ CHAIN_STATE;

    //////////////////////////////////////////////////
    // Round chain
    //////////////////////////////////////////////////

    // Every round sees the same fixed state, the key is what moves along
    for (genvar r = 0; r < NUM_ROUNDS; r++) begin : g_round
        cipher_round u_cipher_round (
            .clk       (clk),
            .state     (CHAIN_STATE),
            .round_key (links[r]),
            .result    (links[r + 1])
        );
    end

    // Total latency is CHAIN_LATENCY cycles
    assign chain_out = links[NUM_ROUNDS];

endmodule

`default_nettype wire

/* verilog/trigger_select.sv */
`timescale 1ns/1ps
`default_nettype none

// Result stage with sticky trigger and key bypass
module trigger_select #(
    parameter round_pkg::block_t TRIGGER_PATTERN = round_pkg::DEFAULT_TRIGGER
) (
    input  logic             clk,
    input  logic             rst,
    input  round_pkg::block_t key,
    input  round_pkg::block_t chain_out,
    output round_pkg::block_t out,
    output logic             triggered
);

    import round_pkg::*;

    logic pattern_hit;

    // Compare on the registered output
    assign pattern_hit = (out == TRIGGER_PATTERN);

    //////////////////////////////////////////////////
    // Sticky flag, cleared by reset only
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            triggered <= 1'b0;
        end else if (pattern_hit) begin
            triggered <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    // Once triggered the live key goes straight out
    always_ff @(posedge clk) begin
        out <= triggered ? key : chain_out;
    end

endmodule

`default_nettype wire

/* verilog/chain_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Round chain followed by the trigger result stage
module chain_top #(
    parameter round_pkg::block_t TRIGGER_PATTERN = round_pkg::DEFAULT_TRIGGER
) (
    input  logic             clk,
    input  logic             rst,
    input  round_pkg::block_t key,
    output round_pkg::block_t out,
    output logic             triggered
);

    import round_pkg::*;

    block_t chain_out;

    round_chain u_round_chain (
        .clk       (clk),
        .key       (key),
        .chain_out (chain_out)
    );

    trigger_select #(
        .TRIGGER_PATTERN (TRIGGER_PATTERN)
    ) u_trigger_select (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .chain_out (chain_out),
        .out       (out),
        .triggered (triggered)
    );

endmodule

`default_nettype wire

/* verification/round_model.svh */
`ifndef ROUND_MODEL_SVH
`define ROUND_MODEL_SVH

//////////////////////////////////////////////////
// Reference AES round in textbook form
//////////////////////////////////////////////////

function automatic byte_t double_byte(input byte_t a);
    return a[7] ? ({a[6:0], 1'b0} ^ 8'h1b) : {a[6:0], 1'b0};
endfunction

// p steps by 3 and q by the inverse of 3 so q stays 1/p
function automatic byte_t model_sbox(input byte_t b);
    byte_t p;
    byte_t q;
    byte_t inv;
    p   = 8'h01;
    q   = 8'h01;
    inv = 8'h00;
    for (int i = 0; i < 255; i++) begin
        p = p ^ double_byte(p);
        q = q ^ {q[6:0], 1'b0};
        q = q ^ {q[5:0], 2'b00};
        q = q ^ {q[3:0], 4'h0};
        q = q[7] ? (q ^ 8'h09) : q;
        if (p == b) begin
            inv = q;
        end
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
        ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// SubBytes and ShiftRows, then MixColumns and AddRoundKey
// Column-major bytes with byte 0 in the top bits
function automatic block_t model_round(input block_t state, input block_t rkey);
    block_t sh;
    block_t mixed;
    byte_t  a0;
    byte_t  a1;
    byte_t  a2;
    byte_t  a3;
    int     src;
    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            // Row r moves left by r columns
            src = 4 * ((c + r) % 4) + r;
            sh[127 - 8*(4*c + r) -: 8] = model_sbox(state[127 - 8*src -: 8]);
        end
    end
    for (int c = 0; c < 4; c++) begin
        a0 = sh[127 - 32*c -: 8];
        a1 = sh[119 - 32*c -: 8];
        a2 = sh[111 - 32*c -: 8];
        a3 = sh[103 - 32*c -: 8];
        mixed[127 - 32*c -: 32] = {
            double_byte(a0) ^ double_byte(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ double_byte(a1) ^ double_byte(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ double_byte(a2) ^ double_byte(a3) ^ a3,
            double_byte(a0) ^ a0 ^ a1 ^ a2 ^ double_byte(a3)
        };
    end
    return mixed ^ rkey;
endfunction

// Whitened key, then each round result becomes the next key
function automatic block_t model_chain(input block_t k);
    block_t rk;
    rk = k ^ CHAIN_STATE;
    for (int r = 0; r < NUM_ROUNDS; r++) begin
        rk = model_round(CHAIN_STATE, rk);
    end
    return rk;
endfunction

`endif

/* verification/chain_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module chain_tb;

    import round_pkg::*;

`include "round_model.svh"

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Four draws per key with the last draw as the new generator state
    function automatic block_t lcg_key(input logic [31:0] seed);
        logic [31:0] s;
        block_t      k;
        s = seed;
        k = '0;
        for (int i = 0; i < 4; i++) begin
            s = lcg_next(s);
            k[127 - 32*i -: 32] = s;
        end
        return k;
    endfunction

    localparam int          CLK_PERIOD  = 4;
    localparam logic [31:0] SEED        = 32'h0c529776;
    localparam int          OUT_LAG     = CHAIN_LATENCY + 1;
    localparam block_t      TRIGGER_KEY = lcg_key(~SEED);
    localparam block_t      PATTERN     = model_chain(TRIGGER_KEY);
    localparam int          IDLE_KEYS   = 20;
    localparam int          STREAM_KEYS = 60;
    localparam int          AFTER_TRIG  = 8;
    localparam int NUM_KEYS = 2 + IDLE_KEYS + (OUT_LAG + 2) + (STREAM_KEYS + OUT_LAG + 1)
                            + (1 + OUT_LAG + 6) + (AFTER_TRIG + 3 + OUT_LAG + 4);
    localparam int WATCHDOG_NS = (NUM_KEYS + 3 * OUT_LAG + 20) * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    block_t      key;
    block_t      out;
    logic        triggered;
    logic [31:0] rng;
    int          err_count = 0;
    int          test_base = 0;
    int          tests_ok  = 0;
    int          tests_bad = 0;

    // Expected state after the latest rising edge
    block_t key_hist [$];
    block_t exp_out    = '0;
    logic   out_known  = 1'b0;
    logic   exp_trig   = 1'b0;
    logic   trig_known = 1'b0;
    logic   rst_prev   = 1'b1;

    always #(CLK_PERIOD / 2) clk = ~clk;

    chain_top #(
        .TRIGGER_PATTERN (PATTERN)
    ) u_chain_top (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .out       (out),
        .triggered (triggered)
    );

    //////////////////////////////////////////////////
    // Reference model updated between rising edges
    //////////////////////////////////////////////////

    // key_hist[0] is the key taken at the last edge
    always @(negedge clk) begin
        block_t next_out;
        logic   next_trig;
        logic   next_trig_known;
        next_out = '0;
        if (trig_known && key_hist.size() > CHAIN_LATENCY) begin
            next_out = exp_trig ? key_hist[0] : model_chain(key_hist[CHAIN_LATENCY]);
        end
        if (rst || rst_prev) begin
            next_trig       = 1'b0;
            next_trig_known = 1'b1;
        end else begin
            next_trig       = exp_trig | (out_known && exp_out == PATTERN);
            next_trig_known = trig_known;
        end
        out_known  = trig_known && key_hist.size() > CHAIN_LATENCY;
        exp_out    = next_out;
        exp_trig   = next_trig;
        trig_known = next_trig_known;
        rst_prev   = rst;
        key_hist.push_front(key);
        if (key_hist.size() > OUT_LAG) begin
            void'(key_hist.pop_back());
        end
    end

    task automatic report_mismatch(input string name, input block_t got, input block_t expected);
        err_count++;
        $display("Fail %s: got %0h expected %0h at %0t", name, got, expected, $time);
    endtask

    assert property (@(posedge clk) !out_known || (out == exp_out))
        else report_mismatch("out", $sampled(out), $sampled(exp_out));

    assert property (@(posedge clk) !trig_known || (triggered == exp_trig))
        else report_mismatch("triggered", $sampled(triggered), $sampled(exp_trig));

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic draw_key(output block_t k);
        k   = lcg_key(rng);
        rng = k[31:0];
    endtask

    task automatic hold_key(input block_t k, input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            key <= k;
        end
    endtask

    task automatic drive_random(input int cycles);
        block_t k;
        repeat (cycles) begin
            draw_key(k);
            hold_key(k, 1);
        end
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        rst <= 1'b1;
        drive_random(2);
        rst <= 1'b0;
    endtask

    // Waits half a cycle so the last assertions have reported
    task automatic close_test(input int num, input string name);
        @(negedge clk);
        if (err_count == test_base) begin
            tests_ok++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", num, name, err_count - test_base);
        end
        test_base = err_count;
    endtask

    initial begin
        block_t k;
        key = '0;
        rng = SEED;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        drive_random(IDLE_KEYS);
        close_test(1, "idle after reset");

        draw_key(k);
        hold_key(k, OUT_LAG + 2);
        close_test(2, "steady key");

        drive_random(STREAM_KEYS + OUT_LAG + 1);
        close_test(3, "new key every cycle");

        hold_key(TRIGGER_KEY, 1);
        drive_random(OUT_LAG + 6);
        close_test(4, "trigger and key bypass");

        drive_random(AFTER_TRIG);
        pulse_reset();
        drive_random(OUT_LAG + 4);
        close_test(5, "sticky flag and reset");

        $display("tests ok %0d, tests with errors %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* Bender.yml */
package:
  name: round_chain

sources:
  - verilog/round_pkg.sv
  - verilog/t_word_lookup.sv
  - verilog/round_lookup.sv
  - verilog/cipher_round.sv
  - verilog/round_chain.sv
  - verilog/trigger_select.sv
  - verilog/chain_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/chain_tb.sv

/* all.f */
+incdir+verification
verilog/round_pkg.sv
verilog/t_word_lookup.sv
verilog/round_lookup.sv
verilog/cipher_round.sv
verilog/round_chain.sv
verilog/trigger_select.sv
verilog/chain_top.sv
verification/chain_tb.sv
